// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_udp_frame_generator
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/crc32_generator.sv ====
module crc32_generator (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        crc_clear,
    input  logic        crc_update,
    input  logic [7:0]  crc_data,
    output logic [31:0] fcs_value
);
    import frame_gen_pkg::*;

    logic [31:0] crc;
    logic [31:0] crc_next;

    // Reflected CRC, one bit per step, LSB first
    always_comb begin
        crc_next = crc ^ {24'd0, crc_data};
        for (int bit_count = 0; bit_count < 8; bit_count++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ CRC32_POLYNOMIAL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc <= '1;
        end else if (crc_clear) begin
            crc <= '1;
        end else if (crc_update) begin
            crc <= crc_next;
        end
    end

    assign fcs_value = ~crc;

endmodule

// ==== hdl/frame_control.sv ====
module frame_control (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  logic                                          enable,
    output logic                                          ready,
    input  logic [15:0]                                   payload_size,
    input  logic                                          header_done,
    output logic                                          header_load,
    output logic [5:0]                                    header_index,
    output logic [1:0]                                    byte_source,
    output logic [1:0]                                    byte_index,
    output logic                                          byte_valid,
    output logic                                          byte_first,
    output logic                                          byte_last,
    output logic                                          crc_clear,
    output logic [frame_gen_pkg::PAYLOAD_ADDRESS_WIDTH-1:0] payload_read_address
);
    import frame_gen_pkg::*;

    logic [2:0]                       phase;
    logic [PAYLOAD_ADDRESS_WIDTH-1:0] count;
    logic [PAYLOAD_ADDRESS_WIDTH-1:0] payload_bytes;
    logic [PAYLOAD_ADDRESS_WIDTH-1:0] pad_bytes;
    logic [15:0]                      pad_length;

    // Zero bytes needed to reach the minimum frame
    assign pad_length = (payload_size < 16'(MINIMUM_PAYLOAD_BYTES)) ?
                        16'(MINIMUM_PAYLOAD_BYTES) - payload_size : 16'd0;

    assign header_load  = (phase == PHASE_IDLE) && ready && enable;
    assign crc_clear    = (phase == PHASE_CHECKSUM) && header_done;
    assign header_index = 6'(HEADER_BYTES - 1) - count[5:0];
    assign byte_index   = 2'(FCS_BYTES - 1) - count[1:0];
    assign byte_first   = (phase == PHASE_HEADER) && (count == 11'(HEADER_BYTES - 1));
    assign byte_last    = (phase == PHASE_FCS) && (count == '0);

    always_comb begin
        byte_source = SOURCE_PAD;
        byte_valid  = 1'b0;
        case (phase)
            PHASE_HEADER: begin
                byte_source = SOURCE_HEADER;
                byte_valid  = 1'b1;
            end
            PHASE_PAYLOAD: begin
                byte_source = SOURCE_PAYLOAD;
                byte_valid  = 1'b1;
            end
            PHASE_PAD: byte_valid = 1'b1;
            PHASE_FCS: begin
                byte_source = SOURCE_FCS;
                byte_valid  = 1'b1;
            end
            default: ;
        endcase
    end

    // Sizes held for the whole frame
    always_ff @(posedge clock) begin
        if (header_load) begin
            payload_bytes <= payload_size[PAYLOAD_ADDRESS_WIDTH-1:0];
            pad_bytes     <= pad_length[PAYLOAD_ADDRESS_WIDTH-1:0];
        end
    end

    //////////////////////////////
    // Phase sequencer
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            phase                <= PHASE_IDLE;
            count                <= '0;
            ready                <= 1'b0;
            payload_read_address <= '0;
        end else begin
            case (phase)
                PHASE_IDLE: begin
                    ready <= 1'b1;
                    if (header_load) begin
                        ready                <= 1'b0;
                        payload_read_address <= '0;
                        phase                <= PHASE_CHECKSUM;
                    end
                end
                PHASE_CHECKSUM: begin
                    if (header_done) begin
                        count <= 11'(HEADER_BYTES - 1);
                        phase <= PHASE_HEADER;
                    end
                end
                PHASE_HEADER: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        // First payload address goes out with the last header byte
                        payload_read_address <= payload_read_address + 1'b1;
                        count                <= payload_bytes - 1'b1;
                        phase                <= PHASE_PAYLOAD;
                    end
                end
                PHASE_PAYLOAD: begin
                    count                <= count - 1'b1;
                    payload_read_address <= payload_read_address + 1'b1;
                    if (count == '0) begin
                        if (pad_bytes != '0) begin
                            count <= pad_bytes - 1'b1;
                            phase <= PHASE_PAD;
                        end else begin
                            count <= 11'(FCS_BYTES - 1);
                            phase <= PHASE_FCS;
                        end
                    end
                end
                PHASE_PAD: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        count <= 11'(FCS_BYTES - 1);
                        phase <= PHASE_FCS;
                    end
                end
                PHASE_FCS: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        count <= 11'(INTER_PACKET_GAP_CYCLES - 1);
                        phase <= PHASE_GAP;
                    end
                end
                PHASE_GAP: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        ready <= 1'b1;
                        phase <= PHASE_IDLE;
                    end
                end
                default: phase <= PHASE_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/frame_gen_pkg.sv ====
package frame_gen_pkg;

    //////////////////////////////
    // Protocol constants
    localparam logic [15:0] ETHERNET_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IPV4_VERSION_IHL   = 8'h45;
    localparam logic [7:0]  IPV4_DSCP          = 8'h00;
    localparam logic [7:0]  IPV4_TIME_TO_LIVE  = 8'h80;
    localparam logic [7:0]  IPV4_PROTOCOL_UDP  = 8'h11;

    //////////////////////////////
    // Frame geometry
    localparam int IPV4_HEADER_HALFWORDS   = 10;
    localparam int HEADER_BYTES            = 42;
    localparam int MINIMUM_PAYLOAD_BYTES   = 18;
    localparam int FCS_BYTES               = 4;
    localparam int UDP_HEADER_BYTES        = 8;
    localparam int IPV4_UDP_OVERHEAD       = 28;
    localparam int MAX_PAYLOAD_BYTES       = 1472;
    localparam int PAYLOAD_ADDRESS_WIDTH   = 11;
    localparam int INTER_PACKET_GAP_CYCLES = 12;

    //////////////////////////////
    // Codes
    localparam logic [31:0] CRC32_POLYNOMIAL = 32'hEDB88320;

    localparam logic [1:0] SOURCE_HEADER  = 2'd0;
    localparam logic [1:0] SOURCE_PAYLOAD = 2'd1;
    localparam logic [1:0] SOURCE_PAD     = 2'd2;
    localparam logic [1:0] SOURCE_FCS     = 2'd3;

    localparam logic [2:0] PHASE_IDLE     = 3'd0;
    localparam logic [2:0] PHASE_CHECKSUM = 3'd1;
    localparam logic [2:0] PHASE_HEADER   = 3'd2;
    localparam logic [2:0] PHASE_PAYLOAD  = 3'd3;
    localparam logic [2:0] PHASE_PAD      = 3'd4;
    localparam logic [2:0] PHASE_FCS      = 3'd5;
    localparam logic [2:0] PHASE_GAP      = 3'd6;

    // IPv4 header, index 0 is the first byte on the wire
    typedef union packed {
        logic [0:19][7:0] bytes;
        logic [0:9][15:0] halfwords;
    } ipv4_header_t;

endpackage

// ==== hdl/frame_output.sv ====
module frame_output (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [1:0]  byte_source,
    input  logic [1:0]  byte_index,
    input  logic        byte_valid,
    input  logic        byte_first,
    input  logic        byte_last,
    input  logic [7:0]  header_byte,
    input  logic [7:0]  payload_read_data,
    input  logic [31:0] fcs_value,
    output logic [7:0]  crc_data,
    output logic        crc_update,
    output logic [7:0]  frame_data,
    output logic        frame_valid,
    output logic        frame_start,
    output logic        frame_last
);
    import frame_gen_pkg::*;

    logic [7:0] selected_byte;

    always_comb begin
        case (byte_source)
            SOURCE_HEADER:  selected_byte = header_byte;
            SOURCE_PAYLOAD: selected_byte = payload_read_data;
            SOURCE_PAD:     selected_byte = 8'h00;
            SOURCE_FCS:     selected_byte = fcs_value[8*byte_index +: 8];
            default:        selected_byte = 8'h00;
        endcase
    end

    // CRC folds the byte being registered, check sequence excluded
    assign crc_data   = selected_byte;
    assign crc_update = byte_valid && (byte_source != SOURCE_FCS);

    always_ff @(posedge clock) begin
        frame_data <= selected_byte;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_last  <= 1'b0;
        end else begin
            frame_valid <= byte_valid;
            frame_start <= byte_first;
            frame_last  <= byte_last;
        end
    end

endmodule

// ==== hdl/header_builder.sv ====
module header_builder (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        header_load,
    input  logic [47:0] mac_destination,
    input  logic [47:0] mac_source,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    input  logic [15:0] ipv4_identification,
    input  logic [15:0] ipv4_flags,
    input  logic [15:0] udp_source,
    input  logic [15:0] udp_destination,
    input  logic [15:0] payload_size,
    input  logic [5:0]  header_index,
    output logic        header_done,
    output logic [7:0]  header_byte
);
    import frame_gen_pkg::*;

    logic [47:0]                      saved_mac_destination;
    logic [47:0]                      saved_mac_source;
    logic [15:0]                      saved_udp_source;
    logic [15:0]                      saved_udp_destination;
    logic [15:0]                      udp_length;
    ipv4_header_t                     ipv4_header;
    logic [15:0]                      total_length;
    logic [15:0]                      sum;
    logic [16:0]                      sum_wide;
    logic [15:0]                      sum_next;
    logic [3:0]                       sum_count;
    logic                             summing;
    logic                             last_step;
    logic [0:HEADER_BYTES-1][7:0]     header_bytes;

    assign total_length = payload_size + 16'(IPV4_UDP_OVERHEAD);

    // Ones' complement add with end-around carry
    assign sum_wide  = {1'b0, sum} + {1'b0, ipv4_header.halfwords[sum_count]};
    assign sum_next  = sum_wide[15:0] + {15'd0, sum_wide[16]};
    assign last_step = (sum_count == 4'(IPV4_HEADER_HALFWORDS - 1));

    always_ff @(posedge clock) begin
        if (header_load) begin
            saved_mac_destination <= mac_destination;
            saved_mac_source      <= mac_source;
            saved_udp_source      <= udp_source;
            saved_udp_destination <= udp_destination;
            udp_length            <= payload_size + 16'(UDP_HEADER_BYTES);
            // Checksum field starts at zero for the sum
            ipv4_header.bytes     <= {IPV4_VERSION_IHL, IPV4_DSCP, total_length,
                                      ipv4_identification, ipv4_flags,
                                      IPV4_TIME_TO_LIVE, IPV4_PROTOCOL_UDP, 16'h0000,
                                      ipv4_source, ipv4_destination};
            sum                   <= '0;
        end else if (summing) begin
            sum <= sum_next;
            if (last_step) begin
                ipv4_header.halfwords[5] <= ~sum_next;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            summing     <= 1'b0;
            sum_count   <= '0;
            header_done <= 1'b0;
        end else begin
            header_done <= 1'b0;
            if (header_load) begin
                summing   <= 1'b1;
                sum_count <= '0;
            end else if (summing) begin
                sum_count <= sum_count + 1'b1;
                if (last_step) begin
                    summing     <= 1'b0;
                    header_done <= 1'b1;
                end
            end
        end
    end

    // MACs, ethertype, IPv4 header, UDP header with zero checksum
    assign header_bytes = {saved_mac_destination, saved_mac_source, ETHERNET_TYPE_IPV4,
                           ipv4_header.bytes, saved_udp_source, saved_udp_destination,
                           udp_length, 16'h0000};
    assign header_byte  = header_bytes[header_index];

endmodule

// ==== hdl/udp_frame_generator.sv ====
module udp_frame_generator (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  logic                                          enable,
    output logic                                          ready,
    input  logic [47:0]                                   mac_destination,
    input  logic [47:0]                                   mac_source,
    input  logic [31:0]                                   ipv4_source,
    input  logic [31:0]                                   ipv4_destination,
    input  logic [15:0]                                   ipv4_identification,
    input  logic [15:0]                                   ipv4_flags,
    input  logic [15:0]                                   udp_source,
    input  logic [15:0]                                   udp_destination,
    input  logic [15:0]                                   payload_size,
    output logic [frame_gen_pkg::PAYLOAD_ADDRESS_WIDTH-1:0] payload_read_address,
    input  logic [7:0]                                    payload_read_data,
    output logic [7:0]                                    frame_data,
    output logic                                          frame_valid,
    output logic                                          frame_start,
    output logic                                          frame_last
);

    logic        header_load;
    logic        header_done;
    logic [5:0]  header_index;
    logic [7:0]  header_byte;
    logic [1:0]  byte_source;
    logic [1:0]  byte_index;
    logic        byte_valid;
    logic        byte_first;
    logic        byte_last;
    logic        crc_clear;
    logic        crc_update;
    logic [7:0]  crc_data;
    logic [31:0] fcs_value;

    frame_control control (
        .clock, .reset_n, .enable, .ready, .payload_size,
        .header_done, .header_load, .header_index,
        .byte_source, .byte_index, .byte_valid, .byte_first, .byte_last,
        .crc_clear, .payload_read_address
    );

    header_builder header (
        .clock, .reset_n, .header_load,
        .mac_destination, .mac_source, .ipv4_source, .ipv4_destination,
        .ipv4_identification, .ipv4_flags, .udp_source, .udp_destination,
        .payload_size, .header_index, .header_done, .header_byte
    );

    crc32_generator crc (
        .clock, .reset_n, .crc_clear, .crc_update, .crc_data, .fcs_value
    );

    frame_output out (
        .clock, .reset_n, .byte_source, .byte_index, .byte_valid, .byte_first,
        .byte_last, .header_byte, .payload_read_data, .fcs_value,
        .crc_data, .crc_update, .frame_data, .frame_valid, .frame_start, .frame_last
    );

endmodule

// ==== src.f ====
+incdir+test
hdl/frame_gen_pkg.sv
hdl/frame_control.sv
hdl/header_builder.sv
hdl/crc32_generator.sv
hdl/frame_output.sv
hdl/udp_frame_generator.sv
test/tb_udp_frame_generator.sv

// ==== test/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

typedef logic [7:0] byte_queue_t[$];

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Ones' complement sum of count halfwords starting at byte first
function automatic logic [15:0] ones_sum(input byte_queue_t data, input int first,
                                         input int count);
    logic [31:0] total;
    total = 32'd0;
    for (int i = 0; i < count; i++) begin
        total = total + {16'd0, data[first + 2 * i], data[first + 2 * i + 1]};
    end
    while (total[31:16] != 16'd0) begin
        total = {16'd0, total[15:0]} + {16'd0, total[31:16]};
    end
    return total[15:0];
endfunction

// Ethernet CRC-32, reflected, bit by bit
function automatic logic [31:0] crc32_of(input byte_queue_t data);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (data[i]) begin
        crc = crc ^ {24'd0, data[i]};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

function automatic byte_queue_t append_bytes(input byte_queue_t q, input logic [63:0] value,
                                             input int count);
    for (int i = count - 1; i >= 0; i--) begin
        q.push_back(value[8 * i +: 8]);
    end
    return q;
endfunction

`endif

// ==== test/tb_udp_frame_generator.sv ====
module tb_udp_frame_generator;
    timeunit 1ns;
    timeprecision 1ps;

    `include "frame_model.svh"

    localparam int NUM_FRAMES    = 24;
    localparam int LONGEST_FRAME = 42 + 64 + 4;
    localparam int GAP_CYCLES    = 12;

    logic clock = 1'b0;
    logic reset_n, enable, ready;
    logic [47:0] mac_destination, mac_source;
    logic [31:0] ipv4_source, ipv4_destination;
    logic [15:0] ipv4_identification, ipv4_flags, udp_source, udp_destination, payload_size;
    logic [10:0] payload_read_address;
    logic [7:0]  payload_read_data = 8'h00;
    logic [7:0]  frame_data;
    logic        frame_valid, frame_start, frame_last;
    logic [7:0]  payload_memory [0:2047];
    logic [31:0] rng = 32'h10b440b7;
    int          errors = 0;
    int          checks = 0;

    udp_frame_generator DUT (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        payload_read_data <= payload_memory[payload_read_address];
    end

    initial begin
        #(NUM_FRAMES * (LONGEST_FRAME + GAP_CYCLES + 40) * 20);
        $display("Watchdog expired before all frames were received");
        $display("Something failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected_value,
                               input logic [31:0] actual_value);
        checks++;
        if (expected_value !== actual_value) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name,
                     expected_value, actual_value);
        end
    endtask

    task automatic next_random(output logic [31:0] value);
        rng = xorshift32(rng);
        value = rng;
    endtask

    function automatic byte_queue_t build_frame(input byte_queue_t payload);
        byte_queue_t frame;
        logic [15:0] checksum;
        logic [31:0] fcs;
        frame = append_bytes(frame, {16'd0, mac_destination}, 6);
        frame = append_bytes(frame, {16'd0, mac_source}, 6);
        frame = append_bytes(frame, 64'h0800, 2);
        frame = append_bytes(frame, 64'h4500, 2);
        frame = append_bytes(frame, {48'd0, 16'(payload.size() + 28)}, 2);
        frame = append_bytes(frame, {32'd0, ipv4_identification, ipv4_flags}, 4);
        frame = append_bytes(frame, 64'h8011_0000, 4);
        frame = append_bytes(frame, {ipv4_source, ipv4_destination}, 8);
        checksum = ~ones_sum(frame, 14, 10);
        frame[24] = checksum[15:8];
        frame[25] = checksum[7:0];
        frame = append_bytes(frame, {udp_source, udp_destination,
                                     16'(payload.size() + 8), 16'h0000}, 8);
        foreach (payload[i]) frame.push_back(payload[i]);
        while (frame.size() < 60) frame.push_back(8'h00);
        // Check sequence goes out low byte first
        fcs = crc32_of(frame);
        frame = append_bytes(frame, {32'd0, fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]}, 4);
        return frame;
    endfunction

    initial begin
        byte_queue_t payload, expected, received;
        logic [31:0] r0, r1, r2, r3;
        int          edges;
        int          idle_edges;
        int          size;
        int          errors_before;
        reset_n = 1'b0;
        enable = 1'b0;
        {mac_destination, mac_source, ipv4_source, ipv4_destination} = '0;
        {ipv4_identification, ipv4_flags, udp_source, udp_destination, payload_size} = '0;
        for (int a = 0; a < 2048; a++) payload_memory[a] = 8'(a ^ (a >> 3));

        //////////////////////////////
        // Reset and first ready
        repeat (5) begin
            @(negedge clock);
            check_value("reset outputs", 0,
                        32'({frame_valid, frame_start, frame_last, ready}));
        end
        @(posedge clock);
        reset_n <= 1'b1;
        repeat (2) @(posedge clock);
        check_value("ready", 1, 32'(ready));
        $display("reset test done, errors %0d", errors);
        idle_edges = 0;

        //////////////////////////////
        // Frames, back to back with enable held high
        for (int f = 0; f < NUM_FRAMES; f++) begin
            errors_before = errors;
            next_random(r0);
            size = (f == 0) ? 5 : (f == 1) ? 40 : 1 + int'(r0 % 64);
            payload.delete();
            for (int i = 0; i < size; i++) begin
                next_random(r1);
                payload.push_back(r1[7:0]);
                payload_memory[i] = r1[7:0];
            end
            next_random(r0);
            next_random(r1);
            next_random(r2);
            next_random(r3);
            mac_destination     <= {r0[15:0], r1};
            mac_source          <= {r0[31:16], r2};
            ipv4_source         <= r3;
            next_random(r0);
            next_random(r1);
            next_random(r2);
            ipv4_destination    <= r0;
            ipv4_identification <= r1[15:0];
            ipv4_flags          <= r1[31:16];
            udp_source          <= r2[15:0];
            udp_destination     <= r2[31:16];
            payload_size        <= 16'(size);
            enable              <= 1'b1;
            // Accepting edge
            do begin
                @(posedge clock);
                idle_edges++;
            end while (!(ready && enable));
            if (f > 0 && idle_edges < GAP_CYCLES) begin
                errors++;
                $display("Gap of %0d cycles before frame %0d is too short", idle_edges, f);
            end
            expected = build_frame(payload);
            edges = 0;
            do begin
                @(posedge clock);
                edges++;
                check_value("ready", 0, 32'(ready));
            end while (!frame_start);
            check_value("start latency", 12, edges - 1);
            received.delete();
            received.push_back(frame_data);
            check_value("frame_valid", 1, 32'(frame_valid));
            while (!frame_last) begin
                @(posedge clock);
                check_value("frame_valid", 1, 32'(frame_valid));
                check_value("ready", 0, 32'(ready));
                received.push_back(frame_data);
            end
            idle_edges = 0;
            check_value("frame length", 42 + ((size > 18) ? size : 18) + 4, received.size());
            for (int i = 0; i < expected.size() && i < received.size(); i++) begin
                check_value($sformatf("frame_data[%0d]", i), 32'(expected[i]),
                            32'(received[i]));
            end
            if (received.size() >= 34) begin
                check_value("ipv4 header sum", 32'hFFFF, 32'(ones_sum(received, 14, 10)));
            end
            $display("frame %0d size %0d %s", f, size, (errors == errors_before) ? "ok" : "FAIL");
        end

        $display("%0d frames, %0d checks, %0d errors", NUM_FRAMES, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
